/* hdl/csr_pkg.sv */
package csr_pkg;

    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [5:0]  ecode_t;

    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    localparam ecode_t ECODE_INT = 6'h00;
    localparam ecode_t ECODE_ADE = 6'h08;
    localparam ecode_t ECODE_ALE = 6'h09;
    localparam ecode_t ECODE_SYS = 6'h0b;
    localparam ecode_t ECODE_BRK = 6'h0c;

    // timer enable in ECFG, pending bit in ESTAT
    localparam int ECFG_TI_BIT = 11;

    typedef enum logic [2:0] {
        OP_CSRRD   = 3'd0,
        OP_CSRWR   = 3'd1,
        OP_CSRXCHG = 3'd2,
        OP_ERTN    = 3'd3,
        OP_EXCP    = 3'd4
    } csr_op_e;

    typedef struct packed {
        csr_op_e   op;
        csr_num_t  num;
        csr_data_t wdata;
        csr_data_t mask;   // xchg only
        csr_data_t pc;
        ecode_t    ecode;
        csr_data_t badv;
    } csr_req_t;

    typedef struct packed {
        csr_data_t rdata;   // value before the access
        logic      redirect;
        csr_data_t redirect_pc;
    } csr_rsp_t;

    typedef struct packed {
        logic      en;
        csr_num_t  num;
        csr_data_t data;
    } csr_wr_t;

    typedef struct packed {
        logic      enter;
        logic      ertn;
        ecode_t    ecode;
        csr_data_t era;
        csr_data_t badv;
    } trap_t;

endpackage

/* hdl/csr_issue_ctrl.sv */
`timescale 1ns/1ps

module csr_issue_ctrl (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_req_t  req,
    input  logic               req_valid,
    output logic               req_ready,
    output csr_pkg::csr_rsp_t  rsp,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    output csr_pkg::csr_num_t  rd_num,
    input  csr_pkg::csr_data_t rd_data_rf,
    input  csr_pkg::csr_data_t rd_data_tmr,
    output csr_pkg::csr_wr_t   wr,
    output csr_pkg::trap_t     trap,
    input  csr_pkg::csr_data_t eentry,
    input  csr_pkg::csr_data_t era,
    input  logic               int_pending
);
    import csr_pkg::*;

    logic      accept;
    logic      take_int;
    logic      do_csr;
    logic      do_ertn;
    logic      do_excp;
    csr_data_t old_val;

    // one item in flight so the slot frees once the held response leaves
    assign req_ready = !rsp_valid || rsp_ready;
    assign accept    = req_valid && req_ready;

    assign take_int = accept && int_pending;   // interrupt wins over the request
    assign do_csr   = accept && !int_pending &&
                      (req.op == OP_CSRWR || req.op == OP_CSRXCHG);
    assign do_ertn  = accept && !int_pending && (req.op == OP_ERTN);
    assign do_excp  = accept && !int_pending && (req.op == OP_EXCP);

    // storage modules return zero for numbers they do not own
    assign rd_num  = req.num;
    assign old_val = rd_data_rf | rd_data_tmr;

    always_comb
    begin
        wr.en  = do_csr;
        wr.num = req.num;
        if (req.op == OP_CSRXCHG)
            wr.data = (old_val & ~req.mask) | (req.wdata & req.mask);
        else
            wr.data = req.wdata;
    end

    always_comb
    begin
        trap.enter = take_int || do_excp;
        trap.ertn  = do_ertn;
        trap.ecode = take_int ? ECODE_INT : req.ecode;
        trap.era   = req.pc;
        trap.badv  = req.badv;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            rsp_valid <= 1'b0;
        else if (accept)
            rsp_valid <= 1'b1;
        else if (rsp_ready)
            rsp_valid <= 1'b0;
    end

    // response payload held under back-pressure
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            rsp.redirect <= take_int || do_excp || do_ertn;
            if (do_ertn)
                rsp.redirect_pc <= era;
            else
                rsp.redirect_pc <= eentry;
            if (take_int || do_excp || do_ertn)
                rsp.rdata <= '0;
            else
                rsp.rdata <= old_val;
        end
    end

endmodule

/* hdl/csr_regfile.sv */
`timescale 1ns/1ps

module csr_regfile (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_num_t  rd_num,
    output csr_pkg::csr_data_t rd_data,
    input  csr_pkg::csr_wr_t   wr,
    input  csr_pkg::trap_t     trap,
    input  logic               timer_irq,
    output csr_pkg::csr_data_t eentry,
    output csr_pkg::csr_data_t era,
    output logic               int_pending
);
    import csr_pkg::*;

    logic [8:0]  crmd;        // datm, datf, pg, da, ie, plv
    logic [2:0]  prmd;        // pie, pplv
    logic        ecfg_ti;
    ecode_t      estat_ecode;
    csr_data_t   era_q;
    csr_data_t   badv;
    logic [25:0] eentry_hi;
    csr_data_t   save [4];
    csr_data_t   estat_rd;
    csr_data_t   ecfg_rd;

    assign eentry      = {eentry_hi, 6'b0};
    assign era         = era_q;
    assign int_pending = crmd[2] && ecfg_ti && timer_irq;

    always_comb
    begin
        ecfg_rd              = '0;
        ecfg_rd[ECFG_TI_BIT] = ecfg_ti;
        estat_rd              = '0;
        estat_rd[21:16]       = estat_ecode;
        estat_rd[ECFG_TI_BIT] = timer_irq;
    end

    always_comb
    begin
        case (rd_num)
            CSR_CRMD:   rd_data = {23'b0, crmd};
            CSR_PRMD:   rd_data = {29'b0, prmd};
            CSR_ECFG:   rd_data = ecfg_rd;
            CSR_ESTAT:  rd_data = estat_rd;
            CSR_ERA:    rd_data = era_q;
            CSR_BADV:   rd_data = badv;
            CSR_EENTRY: rd_data = eentry;
            CSR_SAVE0,
            CSR_SAVE1,
            CSR_SAVE2,
            CSR_SAVE3:  rd_data = save[rd_num[1:0]];
            default:    rd_data = '0;   // timer side or unknown
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd        <= 9'b0_0000_1000;   // da=1
            prmd        <= '0;
            ecfg_ti     <= 1'b0;
            estat_ecode <= '0;
            era_q       <= '0;
            badv        <= '0;
            eentry_hi   <= '0;
            for (int i = 0; i < 4; i++)
                save[i] <= '0;
        end
        else if (trap.enter)
        begin
            prmd        <= crmd[2:0];
            crmd[2:0]   <= 3'b0;
            era_q       <= trap.era;
            estat_ecode <= trap.ecode;
            if (trap.ecode == ECODE_ADE || trap.ecode == ECODE_ALE)
                badv <= trap.badv;
        end
        else if (trap.ertn)
        begin
            crmd[2:0] <= prmd;
        end
        else if (wr.en)
        begin
            case (wr.num)
                CSR_CRMD:
                begin
                    crmd[2:0] <= wr.data[2:0];
                    crmd[8:5] <= wr.data[8:5];
                    if (wr.data[4] ^ wr.data[3])   // da/pg must stay exclusive
                        crmd[4:3] <= wr.data[4:3];
                end
                CSR_PRMD:   prmd      <= wr.data[2:0];
                CSR_ECFG:   ecfg_ti   <= wr.data[ECFG_TI_BIT];
                CSR_ERA:    era_q     <= wr.data;
                CSR_BADV:   badv      <= wr.data;
                CSR_EENTRY: eentry_hi <= wr.data[31:6];
                CSR_SAVE0,
                CSR_SAVE1,
                CSR_SAVE2,
                CSR_SAVE3:  save[wr.num[1:0]] <= wr.data;
                default:    ;   // estat read only here
            endcase
        end
    end

endmodule

/* hdl/csr_timer.sv */
`timescale 1ns/1ps

module csr_timer #(
    parameter int TIMER_W = 32
) (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_num_t  rd_num,
    input  csr_pkg::csr_wr_t   wr,
    output csr_pkg::csr_data_t rd_data,
    output logic               timer_irq
);
    import csr_pkg::*;

    logic [TIMER_W-1:0] tcfg;         // initval, periodic, en
    logic [TIMER_W-1:0] tval;
    logic [TIMER_W-1:0] init_val;
    logic [TIMER_W-1:0] reload_val;
    logic               tcfg_wr;
    logic               ticlr_wr;

    assign tcfg_wr    = wr.en && (wr.num == CSR_TCFG);
    assign ticlr_wr   = wr.en && (wr.num == CSR_TICLR) && wr.data[0];
    assign init_val   = {wr.data[TIMER_W-1:2], 2'b00};
    assign reload_val = {tcfg[TIMER_W-1:2], 2'b00};

    always_comb
    begin
        case (rd_num)
            CSR_TCFG: rd_data = csr_data_t'(tcfg);
            CSR_TVAL: rd_data = csr_data_t'(tval);
            default:  rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg      <= '0;
            tval      <= '0;
            timer_irq <= 1'b0;
        end
        else
        begin
            if (tcfg_wr)
                tcfg <= wr.data[TIMER_W-1:0];

            // clear beats a same-cycle expiry
            if (ticlr_wr)
                timer_irq <= 1'b0;
            else if (tcfg[0] && tval == '0 && !tcfg_wr)
                timer_irq <= 1'b1;

            if (tcfg_wr)
                tval <= init_val;
            else if (tcfg[0])
            begin
                if (tval == '0)
                    tval <= tcfg[1] ? reload_val : '1;   // one-shot parks at all ones
                else if (tval != '1)
                    tval <= tval - 1'b1;
            end
        end
    end

endmodule

/* hdl/csr_unit_top.sv */
`timescale 1ns/1ps

module csr_unit_top #(
    parameter int TIMER_W = 32
) (
    input  logic              clk,
    input  logic              rstn,
    input  csr_pkg::csr_req_t req,
    input  logic              req_valid,
    output logic              req_ready,
    output csr_pkg::csr_rsp_t rsp,
    output logic              rsp_valid,
    input  logic              rsp_ready
);
    import csr_pkg::*;

    csr_num_t  rd_num;
    csr_data_t rd_data_rf;
    csr_data_t rd_data_tmr;
    csr_data_t eentry;
    csr_data_t era;
    csr_wr_t   wr;
    trap_t     trap;
    logic      int_pending;
    logic      timer_irq;

    csr_issue_ctrl u_issue (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .rsp         (rsp),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rd_num      (rd_num),
        .rd_data_rf  (rd_data_rf),
        .rd_data_tmr (rd_data_tmr),
        .wr          (wr),
        .trap        (trap),
        .eentry      (eentry),
        .era         (era),
        .int_pending (int_pending)
    );

    csr_regfile u_regfile (
        .clk         (clk),
        .rstn        (rstn),
        .rd_num      (rd_num),
        .rd_data     (rd_data_rf),
        .wr          (wr),
        .trap        (trap),
        .timer_irq   (timer_irq),
        .eentry      (eentry),
        .era         (era),
        .int_pending (int_pending)
    );

    csr_timer #(
        .TIMER_W (TIMER_W)
    ) u_timer (
        .clk       (clk),
        .rstn      (rstn),
        .rd_num    (rd_num),
        .wr        (wr),
        .rd_data   (rd_data_tmr),
        .timer_irq (timer_irq)
    );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rstn
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    initial
    begin
        rstn = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule

/* tests/csr_unit_tb.sv */
`timescale 1ns/1ps

module csr_unit_tb;
    import csr_pkg::*;

    localparam int WAIT_LIMIT = 50;

    logic        clk;
    logic        rstn;
    csr_req_t    req;
    logic        req_valid;
    logic        req_ready;
    csr_rsp_t    rsp;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] lcg_state;
    int          checks;
    int          errors;
    int          test_errors;
    csr_data_t   save_exp [4];   // shadow of SAVE0-3
    csr_data_t   eentry_exp;

    tb_clock u_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    csr_unit_top #(
        .TIMER_W (32)
    ) UUT (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    function automatic csr_data_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("ERR %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%0t ns: %s", $time, why);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0)
            $display("%s: passed", name);
        else
            $display("%s: failed with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    // runs one request through the handshake from 1 ns after an edge
    task automatic issue(input csr_op_e op, input csr_num_t num, input csr_data_t wdata,
                         input csr_data_t mask, input csr_data_t pc, input ecode_t ecode,
                         input csr_data_t badv, output csr_rsp_t r);
        int n;
        req.op    = op;
        req.num   = num;
        req.wdata = wdata;
        req.mask  = mask;
        req.pc    = pc;
        req.ecode = ecode;
        req.badv  = badv;
        req_valid = 1'b1;
        n = 0;
        while (!req_ready)
        begin
            if (n == WAIT_LIMIT)
                abort_run("request was never accepted");
            @(posedge clk);
            #1;
            n++;
        end
        @(posedge clk);   // accept edge
        #1;
        req_valid = 1'b0;
        n = 0;
        while (!rsp_valid)
        begin
            if (n == WAIT_LIMIT)
                abort_run("no response after an accepted request");
            @(posedge clk);
            #1;
            n++;
        end
        r = rsp;
    endtask

    task automatic csr_rd(input csr_num_t num, output csr_data_t data);
        csr_rsp_t r;
        issue(OP_CSRRD, num, '0, '0, '0, '0, '0, r);
        data = r.rdata;
    endtask

    task automatic csr_wr(input csr_num_t num, input csr_data_t data, output csr_data_t old);
        csr_rsp_t r;
        issue(OP_CSRWR, num, data, '0, '0, '0, '0, r);
        old = r.rdata;
    endtask

    task automatic read_check(input string name, input csr_num_t num, input csr_data_t exp);
        csr_data_t d;
        csr_rd(num, d);
        check_val(name, d, exp);
    endtask

    task automatic read_write_regs();
        csr_data_t d;
        csr_data_t old;
        for (int i = 0; i < 4; i++)
        begin
            d = lcg_next();
            csr_wr(csr_num_t'(CSR_SAVE0 + i), d, old);
            check_val($sformatf("SAVE%0d old", i), old, save_exp[i]);
            save_exp[i] = d;
        end
        for (int i = 0; i < 4; i++)
            read_check($sformatf("SAVE%0d", i), csr_num_t'(CSR_SAVE0 + i), save_exp[i]);
        d = lcg_next();
        csr_wr(CSR_ERA, d, old);
        read_check("ERA", CSR_ERA, d);
        d = lcg_next();
        csr_wr(CSR_BADV, d, old);
        read_check("BADV", CSR_BADV, d);
        d = lcg_next();
        csr_wr(CSR_EENTRY, d, old);
        eentry_exp = d & ~32'h3f;   // entry is 64-byte aligned
        read_check("EENTRY", CSR_EENTRY, eentry_exp);
        report_test("read_write");
    endtask

    task automatic masked_exchange();
        csr_data_t wdata;
        csr_data_t mask;
        csr_data_t merged;
        csr_rsp_t  r;
        for (int i = 0; i < 2; i++)
        begin
            wdata = lcg_next();
            mask  = lcg_next();
            issue(OP_CSRXCHG, CSR_SAVE1, wdata, mask, '0, '0, '0, r);
            check_val("xchg rsp.rdata", r.rdata, save_exp[1]);
            merged = save_exp[1];
            for (int b = 0; b < 32; b++)
                if (mask[b])
                    merged[b] = wdata[b];   // masked bits take the new data
            save_exp[1] = merged;
            read_check("SAVE1 after xchg", CSR_SAVE1, save_exp[1]);
        end
        report_test("exchange");
    endtask

    task automatic exception_return();
        csr_data_t pc;
        csr_data_t badv;
        csr_data_t d;
        csr_rsp_t  r;
        pc   = 32'h1c00_4a10;
        badv = lcg_next();
        csr_wr(CSR_CRMD, 32'h0000_000f, d);   // da, ie, plv 3
        check_val("CRMD old", d, 32'h8);
        issue(OP_EXCP, '0, '0, '0, pc, ECODE_ALE, badv, r);
        check_val("excp rsp.redirect", r.redirect, 1);
        check_val("excp rsp.redirect_pc", r.redirect_pc, eentry_exp);
        read_check("ERA", CSR_ERA, pc);
        read_check("BADV", CSR_BADV, badv);
        csr_rd(CSR_ESTAT, d);
        check_val("ESTAT.ecode", d[21:16], ECODE_ALE);
        csr_rd(CSR_PRMD, d);
        check_val("PRMD pie/pplv", d[2:0], 3'b111);
        csr_rd(CSR_CRMD, d);
        check_val("CRMD ie/plv", d[2:0], 3'b000);
        issue(OP_ERTN, '0, '0, '0, '0, '0, '0, r);
        check_val("ertn rsp.redirect", r.redirect, 1);
        check_val("ertn rsp.redirect_pc", r.redirect_pc, pc);
        csr_rd(CSR_CRMD, d);
        check_val("CRMD ie/plv after ertn", d[2:0], 3'b111);
        report_test("exception");
    endtask

    task automatic timer_interrupt();
        csr_data_t d;
        csr_data_t pc;
        csr_data_t int_pc;
        csr_rsp_t  r;
        logic      got_int;
        csr_wr(CSR_ECFG, 32'h1 << ECFG_TI_BIT, d);
        csr_wr(CSR_CRMD, 32'h0000_000c, d);   // da, ie, plv 0
        csr_wr(CSR_TCFG, 32'h0000_0021, d);   // initial 0x20, one-shot, enabled
        got_int = 1'b0;
        int_pc  = '0;
        for (int i = 0; i < 64 && !got_int; i++)
        begin
            pc = 32'h1c00_8000 + 4 * i;
            issue(OP_CSRRD, CSR_SAVE0, '0, '0, pc, '0, '0, r);
            if (r.redirect)
            begin
                got_int = 1'b1;
                int_pc  = pc;
                check_val("int rsp.redirect_pc", r.redirect_pc, eentry_exp);
            end
        end
        if (!got_int)
            abort_run("timer interrupt was never taken");
        read_check("ERA", CSR_ERA, int_pc);
        csr_rd(CSR_ESTAT, d);
        check_val("ESTAT.ecode", d[21:16], ECODE_INT);
        check_val("ESTAT.ti", d[ECFG_TI_BIT], 1);
        csr_wr(CSR_TICLR, 32'h1, d);
        csr_rd(CSR_ESTAT, d);
        check_val("ESTAT.ti after TICLR", d[ECFG_TI_BIT], 0);
        csr_wr(CSR_TCFG, '0, d);
        csr_wr(CSR_ECFG, '0, d);
        report_test("timer_irq");
    endtask

    task automatic held_response();
        csr_rsp_t  held;
        csr_data_t d;
        issue(OP_CSRRD, CSR_SAVE2, '0, '0, '0, '0, '0, held);
        rsp_ready = 1'b0;   // stall before the response leaves
        check_val("held rsp.rdata", held.rdata, save_exp[2]);
        d = lcg_next();
        req.op    = OP_CSRWR;
        req.num   = CSR_SAVE3;
        req.wdata = d;
        req_valid = 1'b1;
        repeat (4)
        begin
            @(posedge clk);
            #1;
            check_val("req_ready", req_ready, 0);
            check_val("rsp_valid", rsp_valid, 1);
            check_val("rsp.rdata", rsp.rdata, held.rdata);
            check_val("rsp.redirect", rsp.redirect, held.redirect);
            check_val("rsp.redirect_pc", rsp.redirect_pc, held.redirect_pc);
        end
        rsp_ready = 1'b1;
        #1;
        check_val("req_ready on release", req_ready, 1);
        check_val("rsp.rdata on release", rsp.rdata, held.rdata);
        @(posedge clk);   // response taken and queued write accepted
        #1;
        req_valid = 1'b0;
        check_val("rsp_valid after release", rsp_valid, 1);
        check_val("write rsp.rdata", rsp.rdata, save_exp[3]);
        save_exp[3] = d;
        read_check("SAVE3", CSR_SAVE3, d);
        report_test("backpressure");
    endtask

    initial
    begin
        int n;
        req         = '0;
        req_valid   = 1'b0;
        rsp_ready   = 1'b1;
        lcg_state   = 32'hd574_83a9;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        eentry_exp  = '0;
        for (int i = 0; i < 4; i++)
            save_exp[i] = '0;
        n = 0;
        while (rstn !== 1'b1)
        begin
            if (n == WAIT_LIMIT)
                abort_run("reset was never released");
            @(posedge clk);
            n++;
        end
        @(posedge clk);
        #1;
        check_val("rsp_valid", rsp_valid, 0);
        check_val("req_ready", req_ready, 1);
        read_check("CRMD", CSR_CRMD, 32'h8);
        report_test("reset");
        read_write_regs();
        masked_exchange();
        exception_return();
        timer_interrupt();
        held_response();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* csr_unit.f */
hdl/csr_pkg.sv
hdl/csr_issue_ctrl.sv
hdl/csr_regfile.sv
hdl/csr_timer.sv
hdl/csr_unit_top.sv
tests/tb_clock.sv
tests/csr_unit_tb.sv
